/* Bender.yml */
package:
  name: sifh

sources:
  - include_dirs:
      - include
    files:
      - verilog/sifhPkg.sv
      - verilog/histRam.sv
      - verilog/peakScanner.sv
      - verilog/histController.sv
      - verilog/sifhApbRegs.sv
      - verilog/sifhTop.sv

  - target: test
    include_dirs:
      - include
    files:
      - tb/sifhTb.sv

/* all.f */
+incdir+include
verilog/sifhPkg.sv
verilog/histRam.sv
verilog/peakScanner.sv
verilog/histController.sv
verilog/sifhApbRegs.sv
verilog/sifhTop.sv
tb/sifhTb.sv

/* include/sifh_macros.svh */
`ifndef SIFH_MACROS_SVH
`define SIFH_MACROS_SVH

// tdc code width
`define NP          10

// upper code bits that pick the bin, 64 bins
`define BIN_BITS    6

// pixel array size
`define PIXEL_NUM   4
`define PIXEL_BITS  2

// codes per pixel in one acquisition
`define DATA_NUM    8

// histogram counter width
`define CNT_BITS    8

// ram address is {pixel, bin}
`define RAM_ADDR    (`PIXEL_BITS + `BIN_BITS)

// apb register offsets
`define CTRL_OFS    8'h00
`define STATUS_OFS  8'h04
// peak p lives at PEAK_BASE + 4*p
`define PEAK_BASE   8'h10

`endif

/* tb/sifhTb.sv */
`timescale 1ns/10ps
`include "sifh_macros.svh"

module sifhTb;
    import sifhPkg::*;

    localparam int BIN_NUM   = 1 << `BIN_BITS;
    localparam int COUNT_MAX = (1 << `CNT_BITS) - 1;
    // sum of the acquisitions of all six frames
    localparam int TOTAL_ACQ = 51;
    // clear pass plus six frames
    localparam int SCAN_NUM  = 7;
    // worst case two cycles per sample
    localparam int SAMPLE_CYC = TOTAL_ACQ * `PIXEL_NUM * `DATA_NUM * 2;
    localparam int SCAN_CYC   = SCAN_NUM * ((1 << `RAM_ADDR) + 16);
    localparam int APB_CYC    = 300 * 3;
    localparam int CYCLE_LIMIT = SAMPLE_CYC + SCAN_CYC + APB_CYC + 2000;

    // saturation frame code lands in bin 42
    localparam tdcCode_t SAT_CODE  = 'h2A5;
    localparam tdcCode_t NO_PHOTON = '1;

    logic     clk;
    logic     arstN;
    logic     sampleValid;
    tdcCode_t sampleCode;
    logic     sampleReady;
    logic     psel;
    logic     penable;
    logic     pwrite;
    apbAddr_t paddr;
    apbData_t pwdata;
    apbData_t prdata;
    logic     pready;
    logic     pslverr;

    int          errorCount;
    int          checksDone;
    int          cycleCount;
    logic [15:0] lfsrState;
    // expected histogram per pixel with saturation applied
    int          refHist [`PIXEL_NUM][BIN_NUM];

    sifhTop UUT (
        .clk        (clk),
        .arstN      (arstN),
        .sampleValid(sampleValid),
        .sampleCode (sampleCode),
        .sampleReady(sampleReady),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    task automatic checkData(input string name, input apbData_t got, input apbData_t exp);
        checksDone++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic checkCount(input string name, input count_t got, input count_t exp);
        checksDone++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkBin(input string name, input binIdx_t got, input binIdx_t exp);
        checksDone++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        checksDone++;
        if (got !== exp) begin
            errorCount++;
            $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // galois lfsr stepped once per bit
    function automatic logic lfsrBit();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic tdcCode_t randomCode();
        tdcCode_t code;
        code = '0;
        for (int i = 0; i < `NP; i++) begin
            code = {code[`NP-2:0], lfsrBit()};
        end
        return code;
    endfunction

    // mode 1 pins pixel 0 to one code and mode 2 feeds pixel 2 no photons
    function automatic tdcCode_t makeCode(input int mode, input int pixel);
        if (mode == 1 && pixel == 0) begin
            return SAT_CODE;
        end
        if (mode == 2 && pixel == 2) begin
            return NO_PHOTON;
        end
        return randomCode();
    endfunction

    task automatic apbWrite(input apbAddr_t addr, input apbData_t data, output logic err);
        @(posedge clk);
        #0.5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        // mid access phase
        #1;
        checkFlag("pready", pready, 1'b1);
        err = pslverr;
        @(posedge clk);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apbRead(input apbAddr_t addr, output apbData_t data, output logic err);
        @(posedge clk);
        #0.5;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        #1;
        checkFlag("pready", pready, 1'b1);
        data = prdata;
        err  = pslverr;
        @(posedge clk);
        #0.5;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // read a register and expect its value without a slave error
    task automatic readCheck(input apbAddr_t addr, input apbData_t exp, input string name);
        apbData_t data;
        logic     err;
        apbRead(addr, data, err);
        checkData(name, data, exp);
        checkFlag({name, " pslverr"}, err, 1'b0);
    endtask

    task automatic setCtrl(input int acqs);
        logic err;
        apbWrite(`CTRL_OFS, {16'h0, acqCnt_t'(acqs), 7'h0, 1'b1}, err);
        checkFlag("CTRL write pslverr", err, 1'b0);
    endtask

    // starts just after an edge and leaves valid high past the accepting edge
    task automatic streamCode(input tdcCode_t code);
        sampleValid = 1'b1;
        sampleCode  = code;
        #1;
        while (sampleReady !== 1'b1) begin
            @(posedge clk);
            #1.5;
        end
        @(posedge clk);
        #0.5;
    endtask

    task automatic clearRef();
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) begin
                refHist[p][b] = 0;
            end
        end
    endtask

    task automatic addRef(input int pixel, input tdcCode_t code);
        binIdx_t bin;
        bin = code[`NP-1 -: `BIN_BITS];
        // no-photon code only moves the counters
        if (code != NO_PHOTON && refHist[pixel][bin] < COUNT_MAX) begin
            refHist[pixel][bin]++;
        end
    endtask

    // pixel-major stream that skips samples already sent
    task automatic runFrame(input int acqs, input int mode, input int skip);
        int       total;
        int       pixel;
        tdcCode_t code;
        total = acqs * `PIXEL_NUM * `DATA_NUM;
        @(posedge clk);
        #0.5;
        for (int i = skip; i < total; i++) begin
            pixel = (i / `DATA_NUM) % `PIXEL_NUM;
            code  = makeCode(mode, pixel);
            addRef(pixel, code);
            streamCode(code);
        end
        sampleValid = 1'b0;
    endtask

    // poll until frameCount reaches n
    task automatic waitFrame(input int n);
        apbData_t data;
        logic     err;
        data = '0;
        while (data[15:8] != acqCnt_t'(n)) begin
            apbRead(`STATUS_OFS, data, err);
        end
        checkData("STATUS", data, apbData_t'(n) << 8);
    endtask

    task automatic checkPeaks();
        apbData_t data;
        logic     err;
        binIdx_t  expBin;
        int       expCnt;
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            expBin = '0;
            expCnt = refHist[p][0];
            // strictly greater so the lowest bin keeps a tie
            for (int b = 1; b < BIN_NUM; b++) begin
                if (refHist[p][b] > expCnt) begin
                    expBin = binIdx_t'(b);
                    expCnt = refHist[p][b];
                end
            end
            apbRead(`PEAK_BASE + apbAddr_t'(4 * p), data, err);
            checkFlag("PEAK pslverr", err, 1'b0);
            checkBin($sformatf("PEAK%0d bin", p), data[`BIN_BITS-1:0], expBin);
            checkCount($sformatf("PEAK%0d count", p), data[8 +: `CNT_BITS], count_t'(expCnt));
        end
    endtask

    task automatic testRegisters();
        apbData_t data;
        logic     err;
        logic     sawBusy;
        sawBusy = 1'b0;
        data    = 32'h1;
        // clear pass starts right after reset
        while (data[0] === 1'b1) begin
            apbRead(`STATUS_OFS, data, err);
            if (data[0] === 1'b1) begin
                sawBusy = 1'b1;
            end
        end
        if (!sawBusy) begin
            errorCount++;
            $display("clear pass after reset never showed busy in STATUS");
        end
        readCheck(`CTRL_OFS, '0, "CTRL");
        readCheck(`STATUS_OFS, '0, "STATUS");
        for (int p = 0; p < `PIXEL_NUM; p++) begin
            readCheck(`PEAK_BASE + apbAddr_t'(4 * p), '0, $sformatf("PEAK%0d", p));
        end
        apbWrite(`CTRL_OFS, 32'h0000_3701, err);
        checkFlag("CTRL write pslverr", err, 1'b0);
        readCheck(`CTRL_OFS, 32'h0000_3701, "CTRL");
        // read-only and unmapped accesses
        apbWrite(`STATUS_OFS, 32'h1, err);
        checkFlag("STATUS write pslverr", err, 1'b1);
        apbWrite(`PEAK_BASE, 32'h1, err);
        checkFlag("PEAK write pslverr", err, 1'b1);
        apbRead(8'h08, data, err);
        checkFlag("unmapped read pslverr", err, 1'b1);
        apbWrite(8'h40, 32'h1, err);
        checkFlag("unmapped write pslverr", err, 1'b1);
        readCheck(`STATUS_OFS, '0, "STATUS");
    endtask

    task automatic testFrame(input int acqs, input int mode, input int frameNum);
        setCtrl(acqs);
        clearRef();
        runFrame(acqs, mode, 0);
        waitFrame(frameNum);
        checkPeaks();
    endtask

    task automatic testBackPressure();
        apbData_t data;
        logic     err;
        tdcCode_t held;
        setCtrl(2);
        clearRef();
        runFrame(2, 0, 0);
        // frame 5 scan is running now
        held = randomCode();
        @(posedge clk);
        #0.5;
        sampleValid = 1'b1;
        sampleCode  = held;
        #1;
        checkFlag("sampleReady during scan", sampleReady, 1'b0);
        apbRead(`STATUS_OFS, data, err);
        checkFlag("STATUS busy", data[0], 1'b1);
        checkFlag("sampleReady during scan", sampleReady, 1'b0);
        streamCode(held);
        sampleValid = 1'b0;
        waitFrame(5);
        checkPeaks();
        // held code opens frame 6
        clearRef();
        addRef(0, held);
        runFrame(2, 0, 1);
        waitFrame(6);
        checkPeaks();
    endtask

    initial begin
        apbData_t data;
        logic     err;
        clk         = 1'b0;
        arstN       = 1'b0;
        sampleValid = 1'b0;
        sampleCode  = '0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        errorCount  = 0;
        checksDone  = 0;
        cycleCount  = 0;
        lfsrState   = 16'd14;
        clearRef();
        repeat (16) @(posedge clk);
        #0.5;
        arstN = 1'b1;

        testRegisters();
        testFrame(2, 0, 1);
        // new codes so peaks come from this frame only
        testFrame(3, 0, 2);
        // 320 hits on one bin of pixel 0
        testFrame(40, 1, 3);
        apbRead(`PEAK_BASE, data, err);
        checkCount("PEAK0 saturated count", data[8 +: `CNT_BITS], count_t'(COUNT_MAX));
        // pixel 2 sees only no-photon codes
        testFrame(2, 2, 4);
        readCheck(`PEAK_BASE + 8'h08, '0, "PEAK2 no photon");
        testBackPressure();

        $display("checks %0d, errors %0d", checksDone, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

/* verilog/histController.sv */
`timescale 1ns/10ps
`include "sifh_macros.svh"

module histController (
    input  logic               clk,
    input  logic               arstN,
    input  logic               enable,
    input  sifhPkg::acqCnt_t   acqTarget,
    input  logic               sampleValid,
    input  sifhPkg::tdcCode_t  sampleCode,
    output logic               sampleReady,
    output logic               scanBusy,
    output logic               frameDone,
    output sifhPkg::ramAddr_t  raddr,
    output logic               rEnable,
    output sifhPkg::ramAddr_t  waddr,
    output logic               wEnable,
    output sifhPkg::count_t    newCounts,
    input  sifhPkg::count_t    counts,
    output logic               peakValid,
    output sifhPkg::pixelIdx_t peakPixel,
    output sifhPkg::binIdx_t   peakBin,
    output sifhPkg::count_t    peakCount
);
    import sifhPkg::*;

    localparam int DATA_BITS = $clog2(`DATA_NUM);

    ctrlState_t           state;
    // first scan after reset only zeroes the ram
    logic                 clearPass;
    logic                 scanStart;
    // position in the frame
    logic [DATA_BITS-1:0] dataCnt;
    pixelIdx_t            pixelCnt;
    acqCnt_t              acqCnt;
    logic                 accept;
    logic                 photon;
    logic                 lastSample;
    ramAddr_t             accAddr;
    // sample waiting for its read data
    logic                 pendValid;
    ramAddr_t             pendAddr;
    // bypass of the write that raced the read
    logic                 fwdHit;
    count_t               fwdData;
    count_t               baseCount;
    count_t               accCount;
    // scanner side of the ram
    ramAddr_t             scanRaddr;
    ramAddr_t             scanWaddr;
    logic                 scanREnable;
    logic                 scanWEnable;
    logic                 scanEnd;
    logic                 scanPeakValid;

    assign sampleReady = (state == ACCUM);
    assign scanBusy    = (state == SCAN);
    assign accept      = sampleValid && sampleReady;
    assign photon      = (sampleCode != '1);
    // bin is the top code bits
    assign accAddr     = {pixelCnt, sampleCode[`NP-1 -: `BIN_BITS]};
    assign lastSample  = (dataCnt == DATA_BITS'(`DATA_NUM - 1))
                      && (pixelCnt == pixelIdx_t'(`PIXEL_NUM - 1))
                      && (acqCnt == acqCnt_t'(acqTarget - 1'b1));

    // increment with saturation
    assign baseCount = fwdHit ? fwdData : counts;
    assign accCount  = (baseCount == '1) ? baseCount : baseCount + 1'b1;

    // scanner owns the ports while it runs
    // a last pending accumulate write still goes first
    assign rEnable   = scanREnable || (accept && photon);
    assign raddr     = scanREnable ? scanRaddr : accAddr;
    assign wEnable   = pendValid || scanWEnable;
    assign waddr     = pendValid ? pendAddr : scanWaddr;
    assign newCounts = pendValid ? accCount : '0;

    // no peak reports from the clear pass
    assign peakValid = scanPeakValid && !clearPass;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state     <= IDLE;
            clearPass <= 1'b1;
            scanStart <= 1'b0;
            frameDone <= 1'b0;
            dataCnt   <= '0;
            pixelCnt  <= '0;
            acqCnt    <= '0;
            pendValid <= 1'b0;
            fwdHit    <= 1'b0;
        end else begin
            scanStart <= 1'b0;
            frameDone <= 1'b0;
            pendValid <= accept && photon;
            // previous sample writes the word just read
            fwdHit    <= accept && photon && pendValid && (pendAddr == accAddr);
            case (state)
                IDLE: begin
                    if (clearPass) begin
                        state     <= SCAN;
                        scanStart <= 1'b1;
                    end else if (enable) begin
                        state <= ACCUM;
                    end
                end
                ACCUM: begin
                    if (accept) begin
                        if (dataCnt == DATA_BITS'(`DATA_NUM - 1)) begin
                            dataCnt <= '0;
                            if (pixelCnt == pixelIdx_t'(`PIXEL_NUM - 1)) begin
                                pixelCnt <= '0;
                                acqCnt   <= lastSample ? '0 : acqCnt + 1'b1;
                            end else begin
                                pixelCnt <= pixelCnt + 1'b1;
                            end
                        end else begin
                            dataCnt <= dataCnt + 1'b1;
                        end
                        // frame complete, go histogram the peaks
                        if (lastSample) begin
                            state     <= SCAN;
                            scanStart <= 1'b1;
                        end
                    end else if (!enable) begin
                        state <= IDLE;
                    end
                end
                SCAN: begin
                    if (scanEnd) begin
                        state     <= DONE;
                        frameDone <= !clearPass;
                    end
                end
                DONE: begin
                    clearPass <= 1'b0;
                    state     <= enable ? ACCUM : IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // pipeline payload
    always_ff @(posedge clk) begin
        pendAddr <= accAddr;
        fwdData  <= accCount;
    end

    peakScanner scanner (
        .clk        (clk),
        .arstN      (arstN),
        .scanStart  (scanStart),
        .scanRaddr  (scanRaddr),
        .scanREnable(scanREnable),
        .scanWaddr  (scanWaddr),
        .scanWEnable(scanWEnable),
        .counts     (counts),
        .scanEnd    (scanEnd),
        .peakValid  (scanPeakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

endmodule

/* verilog/histRam.sv */
`timescale 1ns/10ps
`include "sifh_macros.svh"

module histRam (
    input  logic              clk,
    input  sifhPkg::ramAddr_t waddr,
    input  sifhPkg::ramAddr_t raddr,
    input  logic              wEnable,
    input  sifhPkg::count_t   newCounts,
    input  logic              rEnable,
    output sifhPkg::count_t   counts
);
    import sifhPkg::*;

    localparam int DEPTH = 1 << `RAM_ADDR;

    // one count per {pixel, bin}
    count_t mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clk) begin
        if (wEnable) begin
            mem[waddr] <= newCounts;
        end
    end

    // registered read, one cycle latency
    // same-cycle write to the read address returns the old word
    always_ff @(posedge clk) begin
        if (rEnable) begin
            counts <= mem[raddr];
        end
    end

endmodule

/* verilog/peakScanner.sv */
`timescale 1ns/10ps
`include "sifh_macros.svh"

module peakScanner (
    input  logic               clk,
    input  logic               arstN,
    input  logic               scanStart,
    output sifhPkg::ramAddr_t  scanRaddr,
    output logic               scanREnable,
    output sifhPkg::ramAddr_t  scanWaddr,
    output logic               scanWEnable,
    input  sifhPkg::count_t    counts,
    output logic               scanEnd,
    output logic               peakValid,
    output sifhPkg::pixelIdx_t peakPixel,
    output sifhPkg::binIdx_t   peakBin,
    output sifhPkg::count_t    peakCount
);
    import sifhPkg::*;

    // read side
    ramAddr_t  rdAddr;
    logic      rdActive;
    // address whose data is on counts this cycle
    ramAddr_t  rtnAddr;
    logic      rtnValid;
    binIdx_t   rtnBin;
    pixelIdx_t rtnPixel;
    logic      firstBin;
    logic      lastBin;
    logic      takeNew;
    // running maximum of the current pixel
    count_t    maxCount;
    binIdx_t   maxBin;
    count_t    nextCount;
    binIdx_t   nextBin;

    assign scanRaddr   = rdAddr;
    assign scanREnable = rdActive;
    // zero goes back to the word read one cycle earlier
    assign scanWaddr   = rtnAddr;
    assign scanWEnable = rtnValid;

    assign rtnBin   = rtnAddr[`BIN_BITS-1:0];
    assign rtnPixel = rtnAddr[`RAM_ADDR-1:`BIN_BITS];
    assign firstBin = (rtnBin == '0);
    assign lastBin  = (rtnBin == '1);

    // bin 0 restarts the search
    // strictly greater only so the lowest bin wins a tie
    assign takeNew   = firstBin || (counts > maxCount);
    assign nextCount = takeNew ? counts : maxCount;
    assign nextBin   = takeNew ? rtnBin : maxBin;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rdActive  <= 1'b0;
            rdAddr    <= '0;
            rtnValid  <= 1'b0;
            peakValid <= 1'b0;
            scanEnd   <= 1'b0;
        end else begin
            if (scanStart) begin
                rdActive <= 1'b1;
                rdAddr   <= '0;
            end else if (rdActive) begin
                rdAddr <= rdAddr + 1'b1;
                // stop after the top address
                if (rdAddr == '1) begin
                    rdActive <= 1'b0;
                end
            end
            rtnValid  <= rdActive;
            // strobe at each pixel boundary
            peakValid <= rtnValid && lastBin;
            // last pixel done
            scanEnd   <= rtnValid && (rtnAddr == '1);
        end
    end

    // return address, running maximum and peak result
    always_ff @(posedge clk) begin
        rtnAddr <= rdAddr;
        if (rtnValid) begin
            maxCount <= nextCount;
            maxBin   <= nextBin;
        end
        if (rtnValid && lastBin) begin
            peakPixel <= rtnPixel;
            peakBin   <= nextBin;
            peakCount <= nextCount;
        end
    end

endmodule

/* verilog/sifhApbRegs.sv */
`timescale 1ns/10ps
`include "sifh_macros.svh"

module sifhApbRegs (
    input  logic               clk,
    input  logic               arstN,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  sifhPkg::apbAddr_t  paddr,
    input  sifhPkg::apbData_t  pwdata,
    output sifhPkg::apbData_t  prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               enable,
    output sifhPkg::acqCnt_t   acqTarget,
    input  logic               scanBusy,
    input  logic               frameDone,
    input  logic               peakValid,
    input  sifhPkg::pixelIdx_t peakPixel,
    input  sifhPkg::binIdx_t   peakBin,
    input  sifhPkg::count_t    peakCount
);
    import sifhPkg::*;

    // address decode
    logic      isCtrl;
    logic      isStatus;
    logic      isPeak;
    apbAddr_t  peakOfs;
    pixelIdx_t peakSel;
    logic      access;
    logic      ctrlWrite;
    // frames finished since reset
    acqCnt_t   frameCount;
    // one result per pixel
    binIdx_t   peakBinReg   [`PIXEL_NUM];
    count_t    peakCountReg [`PIXEL_NUM];

    assign peakOfs  = paddr - `PEAK_BASE;
    assign peakSel  = peakOfs[`PIXEL_BITS+1:2];
    assign isCtrl   = (paddr == `CTRL_OFS);
    assign isStatus = (paddr == `STATUS_OFS);
    assign isPeak   = (paddr >= `PEAK_BASE)
                   && (peakOfs < apbAddr_t'(4 * `PIXEL_NUM))
                   && (peakOfs[1:0] == 2'b00);

    // zero wait states
    assign access    = psel && penable;
    assign pready    = access;
    assign ctrlWrite = access && pwrite && isCtrl;

    // unmapped, or a write to a read-only register
    assign pslverr = access
                  && (!(isCtrl || isStatus || isPeak) || (pwrite && (isStatus || isPeak)));

    // read mux
    always_comb begin
        prdata = '0;
        if (isCtrl) begin
            prdata[0]    = enable;
            prdata[15:8] = acqTarget;
        end else if (isStatus) begin
            prdata[0]    = scanBusy;
            prdata[15:8] = frameCount;
        end else if (isPeak) begin
            prdata[`BIN_BITS-1:0]    = peakBinReg[peakSel];
            prdata[8+`CNT_BITS-1:8]  = peakCountReg[peakSel];
        end
    end

    // ctrl and frame counter
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            enable     <= 1'b0;
            acqTarget  <= '0;
            frameCount <= '0;
        end else begin
            if (ctrlWrite) begin
                enable    <= pwdata[0];
                acqTarget <= pwdata[15:8];
            end
            // wraps at 256
            if (frameDone) begin
                frameCount <= frameCount + 1'b1;
            end
        end
    end

    // peak results, loaded by the scanner strobe
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `PIXEL_NUM; i++) begin
                peakBinReg[i]   <= '0;
                peakCountReg[i] <= '0;
            end
        end else if (peakValid) begin
            peakBinReg[peakPixel]   <= peakBin;
            peakCountReg[peakPixel] <= peakCount;
        end
    end

endmodule

/* verilog/sifhPkg.sv */
`include "sifh_macros.svh"

package sifhPkg;

    // raw tdc code
    // all-ones code means no photon was seen
    typedef logic [`NP-1:0] tdcCode_t;

    // histogram bin number
    typedef logic [`BIN_BITS-1:0] binIdx_t;

    // pixel number
    typedef logic [`PIXEL_BITS-1:0] pixelIdx_t;

    // one histogram count
    typedef logic [`CNT_BITS-1:0] count_t;

    // ram word address {pixel, bin}
    typedef logic [`RAM_ADDR-1:0] ramAddr_t;

    // acquisitions per frame, 0 means 256
    typedef logic [7:0] acqCnt_t;

    // apb address and data
    typedef logic [7:0] apbAddr_t;
    typedef logic [31:0] apbData_t;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        ACCUM,
        SCAN,
        DONE
    } ctrlState_t;

endpackage

/* verilog/sifhTop.sv */
`timescale 1ns/10ps

module sifhTop (
    input  logic              clk,
    input  logic              arstN,
    input  logic              sampleValid,
    input  sifhPkg::tdcCode_t sampleCode,
    output logic              sampleReady,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  sifhPkg::apbAddr_t paddr,
    input  sifhPkg::apbData_t pwdata,
    output sifhPkg::apbData_t prdata,
    output logic              pready,
    output logic              pslverr
);
    import sifhPkg::*;

    // register block to controller
    logic      enable;
    acqCnt_t   acqTarget;
    logic      scanBusy;
    logic      frameDone;
    // peak results
    logic      peakValid;
    pixelIdx_t peakPixel;
    binIdx_t   peakBin;
    count_t    peakCount;
    // ram ports
    ramAddr_t  raddr;
    ramAddr_t  waddr;
    logic      rEnable;
    logic      wEnable;
    count_t    newCounts;
    count_t    counts;

    sifhApbRegs regs (
        .clk      (clk),
        .arstN    (arstN),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .enable   (enable),
        .acqTarget(acqTarget),
        .scanBusy (scanBusy),
        .frameDone(frameDone),
        .peakValid(peakValid),
        .peakPixel(peakPixel),
        .peakBin  (peakBin),
        .peakCount(peakCount)
    );

    histController ctrl (
        .clk        (clk),
        .arstN      (arstN),
        .enable     (enable),
        .acqTarget  (acqTarget),
        .sampleValid(sampleValid),
        .sampleCode (sampleCode),
        .sampleReady(sampleReady),
        .scanBusy   (scanBusy),
        .frameDone  (frameDone),
        .raddr      (raddr),
        .rEnable    (rEnable),
        .waddr      (waddr),
        .wEnable    (wEnable),
        .newCounts  (newCounts),
        .counts     (counts),
        .peakValid  (peakValid),
        .peakPixel  (peakPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    histRam ram (
        .clk      (clk),
        .waddr    (waddr),
        .raddr    (raddr),
        .wEnable  (wEnable),
        .newCounts(newCounts),
        .rEnable  (rEnable),
        .counts   (counts)
    );

endmodule
